//--- i2c_write_pkg.sv
// shared definitions for the one-shot i2c eeprom byte writer
// bus constants, sequencer enums and the structs passed between stages
// referenced by scoped name from the rtl and the testbench monitor

package i2c_write_pkg;

        // upper nibble of the 24c16 control byte (device type)
        localparam logic [3:0] ctrl_nibble = 4'b1010;

        // quarter phases per bit time, tracked by a 2-bit phase counter
        localparam int qtr_per_bit = 4;

        // one write request as captured at the end of the power-up delay
        typedef struct packed {
                logic [2:0] blk_sel;    // block select, goes into the control byte
                logic [7:0] mem_addr;   // word address inside the block
                logic [7:0] wr_data;    // byte to store
        } i2c_req_t;

        // bus line levels for one quarter phase
        typedef struct packed {
                logic scl;
                logic sda_out;          // value driven when sda_oe is set
                logic sda_oe;           // 0 releases sda to the pullup
        } line_ctl_t;

        // frame sequencer states
        typedef enum logic [2:0] {
                IDLE,
                START,
                SEND_BIT,
                ACK_SLOT,
                STOP,
                DONE
        } frame_state_e;

        // which byte of the write frame is on the bus
        typedef enum logic [1:0] {
                CTRL_BYTE,
                ADDR_BYTE,
                DATA_BYTE
        } byte_sel_e;

endpackage

//--- i2c_launch_ctrl.sv
// launch side of the writer: waits out the eeprom power-up delay,
// captures the request from the input pins and pulses go once,
// then produces the quarter-bit tick that paces the frame sequencer

`timescale 1ns/1ps

module i2c_launch_ctrl #(
        parameter int powerup_cycles = 100_000_000,
        parameter int qtr_div        = 250
) (
        input  logic                    sys_clk,
        input  logic                    sys_rst_n,
        input  logic [2:0]              blk_sel,
        input  logic [7:0]              mem_addr,
        input  logic [7:0]              wr_data,
        output i2c_write_pkg::i2c_req_t req,
        output logic                    go,
        output logic                    qtick
);

        localparam int pu_w  = $clog2(powerup_cycles + 1);
        localparam int div_w = $clog2(qtr_div + 1);

        logic [pu_w-1:0]  pu_cnt;       // saturates at powerup_cycles
        logic [div_w-1:0] div_cnt;
        logic             pu_last;      // last cycle of the delay
        logic             running;      // delay over, ticks enabled

        assign pu_last = (pu_cnt == pu_w'(powerup_cycles - 1));
        assign running = (pu_cnt == pu_w'(powerup_cycles));

        always_ff @(posedge sys_clk or negedge sys_rst_n) begin
                if (!sys_rst_n) begin
                        pu_cnt <= '0;
                        go     <= 1'b0;
                end else begin
                        go <= pu_last;                  // single pulse, counter stops past it
                        if (!running)
                                pu_cnt <= pu_cnt + 1'b1;
                end
        end

        // request fields are sampled together with go
        always_ff @(posedge sys_clk) begin
                if (pu_last) begin
                        req.blk_sel  <= blk_sel;
                        req.mem_addr <= mem_addr;
                        req.wr_data  <= wr_data;
                end
        end

        // quarter-bit divider, first tick lands qtr_div cycles after go
        always_ff @(posedge sys_clk or negedge sys_rst_n) begin
                if (!sys_rst_n) begin
                        div_cnt <= '0;
                        qtick   <= 1'b0;
                end else if (running) begin
                        qtick <= (div_cnt == div_w'(qtr_div - 1));
                        if (div_cnt == div_w'(qtr_div - 1))
                                div_cnt <= '0;
                        else
                                div_cnt <= div_cnt + 1'b1;
                end
        end

endmodule

//--- i2c_write_fsm.sv
// frame sequencer for one eeprom byte write
// steps one quarter phase per qtick through start, three bytes with
// their acknowledge slots, and stop; emits the line levels for each quarter
// done is a one-cycle pulse on the final qtick of the stop bit

`timescale 1ns/1ps

module i2c_write_fsm (
        input  logic                     sys_clk,
        input  logic                     sys_rst_n,
        input  i2c_write_pkg::i2c_req_t  req,
        input  logic                     go,
        input  logic                     qtick,
        output i2c_write_pkg::line_ctl_t line,
        output logic                     done,
        output logic [7:0]               data_byte
);

        localparam logic [1:0] last_qtr = 2'(i2c_write_pkg::qtr_per_bit - 1);

        i2c_write_pkg::frame_state_e state;
        i2c_write_pkg::byte_sel_e    byte_sel;
        logic [1:0]                  phase;     // quarter within the current bit
        logic [2:0]                  bit_idx;   // bits left in the byte, 7 down to 0
        logic [7:0]                  shift_q;   // msb is on the bus
        logic                        bit_end;   // qtick closing the current bit

        // byte image for each slot of the frame
        function automatic logic [7:0] frame_byte(input i2c_write_pkg::byte_sel_e sel,
                                                  input i2c_write_pkg::i2c_req_t r);
                logic [7:0] b;
                case (sel)
                        i2c_write_pkg::CTRL_BYTE: b = {i2c_write_pkg::ctrl_nibble, r.blk_sel, 1'b0};
                        i2c_write_pkg::ADDR_BYTE: b = r.mem_addr;
                        default:                  b = r.wr_data;
                endcase
                return b;
        endfunction

        assign bit_end = qtick && (phase == last_qtr);

        always_ff @(posedge sys_clk or negedge sys_rst_n) begin
                if (!sys_rst_n) begin
                        state    <= i2c_write_pkg::IDLE;
                        byte_sel <= i2c_write_pkg::CTRL_BYTE;
                        phase    <= 2'd0;
                        bit_idx  <= 3'd7;
                end else begin
                        case (state)
                                i2c_write_pkg::IDLE: begin
                                        if (go) begin
                                                state    <= i2c_write_pkg::START;
                                                byte_sel <= i2c_write_pkg::CTRL_BYTE;
                                                phase    <= 2'd0;
                                                bit_idx  <= 3'd7;
                                        end
                                end
                                i2c_write_pkg::START: begin
                                        if (bit_end)
                                                state <= i2c_write_pkg::SEND_BIT;
                                end
                                i2c_write_pkg::SEND_BIT: begin
                                        if (bit_end) begin
                                                if (bit_idx == 3'd0)
                                                        state <= i2c_write_pkg::ACK_SLOT;
                                                else
                                                        bit_idx <= bit_idx - 1'b1;
                                        end
                                end
                                i2c_write_pkg::ACK_SLOT: begin
                                        if (bit_end) begin
                                                bit_idx <= 3'd7;
                                                case (byte_sel)
                                                        i2c_write_pkg::CTRL_BYTE: begin
                                                                byte_sel <= i2c_write_pkg::ADDR_BYTE;
                                                                state    <= i2c_write_pkg::SEND_BIT;
                                                        end
                                                        i2c_write_pkg::ADDR_BYTE: begin
                                                                byte_sel <= i2c_write_pkg::DATA_BYTE;
                                                                state    <= i2c_write_pkg::SEND_BIT;
                                                        end
                                                        default: state <= i2c_write_pkg::STOP;
                                                endcase
                                        end
                                end
                                i2c_write_pkg::STOP: begin
                                        if (bit_end)
                                                state <= i2c_write_pkg::DONE;
                                end
                                default: ;      // DONE holds until the next reset
                        endcase

                        if (qtick && state != i2c_write_pkg::IDLE &&
                            state != i2c_write_pkg::DONE)
                                phase <= phase + 2'd1;  // wraps at the bit boundary
                end
        end

        // shift register, reloaded at each byte boundary
        always_ff @(posedge sys_clk) begin
                if (state == i2c_write_pkg::IDLE && go)
                        shift_q <= frame_byte(i2c_write_pkg::CTRL_BYTE, req);
                else if (bit_end && state == i2c_write_pkg::SEND_BIT)
                        shift_q <= {shift_q[6:0], 1'b0};        // msb first
                else if (bit_end && state == i2c_write_pkg::ACK_SLOT) begin
                        if (byte_sel == i2c_write_pkg::CTRL_BYTE)
                                shift_q <= frame_byte(i2c_write_pkg::ADDR_BYTE, req);
                        else
                                shift_q <= frame_byte(i2c_write_pkg::DATA_BYTE, req);
                end
        end

        // line levels per state and quarter
        always_comb begin
                line.scl     = 1'b1;
                line.sda_out = 1'b1;
                line.sda_oe  = 1'b0;
                case (state)
                        i2c_write_pkg::START: begin
                                line.scl     = (phase != 2'd3);         // sda falls in q2 with scl high
                                line.sda_out = (phase < 2'd2);
                                line.sda_oe  = 1'b1;
                        end
                        i2c_write_pkg::SEND_BIT: begin
                                line.scl     = (phase == 2'd1) || (phase == 2'd2);
                                line.sda_out = shift_q[7];
                                line.sda_oe  = 1'b1;
                        end
                        i2c_write_pkg::ACK_SLOT: begin
                                line.scl = (phase == 2'd1) || (phase == 2'd2);  // sda left to the slave
                        end
                        i2c_write_pkg::STOP: begin
                                line.scl     = (phase != 2'd0);
                                line.sda_out = (phase >= 2'd2);         // rises in q2 with scl high
                                line.sda_oe  = 1'b1;
                        end
                        default: ;      // idle bus, scl high and sda released
                endcase
        end

        assign done      = bit_end && (state == i2c_write_pkg::STOP);
        assign data_byte = req.wr_data;

endmodule

//--- i2c_output_stage.sv
// pin stage of the writer: registers scl and sda so the pins change
// on clean clock edges, drives the sda pad only while enabled,
// and latches the written byte into the status leds at frame end

`timescale 1ns/1ps

module i2c_output_stage (
        input  logic                     sys_clk,
        input  logic                     sys_rst_n,
        input  i2c_write_pkg::line_ctl_t line,
        input  logic                     done,
        input  logic [7:0]               data_byte,
        output logic                     i2c_scl,
        output logic [7:0]               led,
        inout  wire                      i2c_sda
);

        i2c_write_pkg::line_ctl_t pins_q;

        // one register stage on all bus lines, idle bus out of reset
        always_ff @(posedge sys_clk or negedge sys_rst_n) begin
                if (!sys_rst_n) begin
                        pins_q.scl     <= 1'b1;
                        pins_q.sda_out <= 1'b1;
                        pins_q.sda_oe  <= 1'b0;
                end else begin
                        pins_q <= line;
                end
        end

        assign i2c_scl = pins_q.scl;
        assign i2c_sda = pins_q.sda_oe ? pins_q.sda_out : 1'bz;        // released -> pullup

        // status byte shows what was written, held until reset
        always_ff @(posedge sys_clk or negedge sys_rst_n) begin
                if (!sys_rst_n)
                        led <= 8'h00;
                else if (done)
                        led <= data_byte;
        end

endmodule

//--- i2c_write_top.sv
// top level of the one-shot i2c eeprom byte writer
// launch control -> frame sequencer -> pin stage
// powerup_cycles and qtr_div are set here and passed down

`timescale 1ns/1ps

module i2c_write_top #(
        parameter int powerup_cycles = 100_000_000,     // 2 s at 50 MHz
        parameter int qtr_div        = 250              // 50 kHz scl at 50 MHz
) (
        input  logic       sys_clk,
        input  logic       sys_rst_n,
        input  logic [2:0] blk_sel,
        input  logic [7:0] mem_addr,
        input  logic [7:0] wr_data,
        output logic       i2c_scl,
        output logic [7:0] led,
        inout  wire        i2c_sda
);

        i2c_write_pkg::i2c_req_t  req;
        i2c_write_pkg::line_ctl_t line;
        logic                     go;
        logic                     qtick;
        logic                     done;
        logic [7:0]               data_byte;

        i2c_launch_ctrl #(
                .powerup_cycles (powerup_cycles),
                .qtr_div        (qtr_div)
        ) u_launch (
                .sys_clk   (sys_clk),
                .sys_rst_n (sys_rst_n),
                .blk_sel   (blk_sel),
                .mem_addr  (mem_addr),
                .wr_data   (wr_data),
                .req       (req),
                .go        (go),
                .qtick     (qtick)
        );

        i2c_write_fsm u_fsm (
                .sys_clk   (sys_clk),
                .sys_rst_n (sys_rst_n),
                .req       (req),
                .go        (go),
                .qtick     (qtick),
                .line      (line),
                .done      (done),
                .data_byte (data_byte)
        );

        i2c_output_stage u_out (
                .sys_clk   (sys_clk),
                .sys_rst_n (sys_rst_n),
                .line      (line),
                .done      (done),
                .data_byte (data_byte),
                .i2c_scl   (i2c_scl),
                .led       (led),
                .i2c_sda   (i2c_sda)
        );

endmodule

//--- i2c_bus_monitor.sv
// bus monitor for the i2c byte writer testbench
// decodes start, data bits and stop from the pins and compares each frame
// and the status leds with the request armed by the testbench top
// keeps the pass and fail counts that the top prints at the end

`timescale 1ns/1ps

module i2c_bus_monitor #(
        parameter int powerup_cycles = 20,
        parameter int qtr_div        = 4
) (
        input logic       sys_clk,
        input logic       sys_rst_n,
        input logic       i2c_scl,
        input wire        i2c_sda,
        input logic [7:0] led
);

        localparam int frame_bits = 27;                 // 3 bytes, each with its ack slot
        localparam int led_limit  = 2 * qtr_div + 2;    // stop is two quarters before done
        localparam int idle_after = led_limit + i2c_write_pkg::qtr_per_bit * qtr_div;

        string                       test_name;
        i2c_write_pkg::i2c_req_t     exp_req;
        i2c_write_pkg::frame_state_e mon_state;
        int                          errs;
        int                          pass_count = 0;
        int                          fail_count = 0;
        logic                        frame_closed = 1'b0;
        logic                        scl_q, sda_q;      // previous sample of the pins
        logic                        start_c, stop_c, scl_rise, scl_fall;
        logic                        pend_bit, pend_valid;
        logic [frame_bits-1:0]       bits;
        int                          pulses, cyc_cnt, wait_cnt;
        logic                        idle_bad, led_bad, led_ok;
        logic                        bus_busy;          // either pin away from idle level

        task automatic arm_frame(input string name, input i2c_write_pkg::i2c_req_t req);
                test_name    = name;
                exp_req      = req;
                errs         = 0;
                frame_closed = 1'b0;
        endtask

        task automatic report_mismatch(input string what, input logic [7:0] exp_v,
                                       input logic [7:0] act_v);
                $display("MISMATCH %s %s: expected %02h, actual %02h",
                         test_name, what, exp_v, act_v);
                errs++;
        endtask

        task automatic report_problem(input string msg);
                $display("ERROR %s: %s", test_name, msg);
                errs++;
        endtask

        task automatic report_missing(input int waited);
                $display("test %s: no complete frame seen within %0d cycles", test_name, waited);
                fail_count++;
        endtask

        task automatic close_test();
                if (errs == 0) begin
                        $display("test %s: ok", test_name);
                        pass_count++;
                end else begin
                        $display("test %s: %0d error(s)", test_name, errs);
                        fail_count++;
                end
                frame_closed = 1'b1;
        endtask

        // bit 26 is the first bit on the bus, each byte followed by its ack slot
        task automatic compare_frame();
                i2c_write_pkg::byte_sel_e sel;
                logic [7:0]               exp_b;
                int                       k;
                int                       pos;
                for (k = 0; k < 3; k++) begin
                        sel = i2c_write_pkg::byte_sel_e'(k);
                        pos = frame_bits - 1 - 9 * k;
                        case (sel)
                                i2c_write_pkg::CTRL_BYTE:
                                        exp_b = {i2c_write_pkg::ctrl_nibble, exp_req.blk_sel, 1'b0};
                                i2c_write_pkg::ADDR_BYTE: exp_b = exp_req.mem_addr;
                                default:                  exp_b = exp_req.wr_data;
                        endcase
                        if (bits[pos -: 8] !== exp_b)
                                report_mismatch(sel.name(), exp_b, bits[pos -: 8]);
                        if (bits[pos - 8] !== 1'b1)
                                report_problem($sformatf("sda driven low in the ack slot after %s",
                                                         sel.name()));
                end
        endtask

        always @(posedge sys_clk) begin
                if (!sys_rst_n) begin
                        mon_state  = i2c_write_pkg::IDLE;
                        scl_q      = 1'b1;
                        sda_q      = 1'b1;
                        cyc_cnt    = 0;
                        pulses     = 0;
                        pend_valid = 1'b0;
                        idle_bad   = 1'b0;
                end else begin
                        start_c  = scl_q && i2c_scl && (sda_q === 1'b1) && (i2c_sda === 1'b0);
                        stop_c   = scl_q && i2c_scl && (sda_q === 1'b0) && (i2c_sda === 1'b1);
                        scl_rise = !scl_q && i2c_scl;
                        scl_fall = scl_q && !i2c_scl;
                        bus_busy = (i2c_scl !== 1'b1) || (i2c_sda !== 1'b1);
                        case (mon_state)
                                i2c_write_pkg::IDLE: begin
                                        cyc_cnt++;
                                        if (start_c) begin
                                                if (cyc_cnt < powerup_cycles)
                                                        report_problem($sformatf(
                                                                "start %0d cycles after reset, %s %0d",
                                                                cyc_cnt, "delay is", powerup_cycles));
                                                mon_state  = i2c_write_pkg::SEND_BIT;
                                                bits       = '0;
                                                led_bad    = 1'b0;
                                        end else if (stop_c) begin
                                                report_problem("stop condition before any start");
                                        end else if (bus_busy && !idle_bad) begin
                                                idle_bad = 1'b1;
                                                report_problem("bus not idle before the start condition");
                                        end
                                end
                                i2c_write_pkg::SEND_BIT: begin
                                        if (start_c) begin
                                                report_problem("repeated start inside the frame");
                                        end else if (stop_c) begin
                                                if (pulses != frame_bits)
                                                        report_problem($sformatf(
                                                                "frame held %0d scl high pulses, expected %0d",
                                                                pulses, frame_bits));
                                                else
                                                        compare_frame();
                                                mon_state = i2c_write_pkg::STOP;
                                                wait_cnt  = 0;
                                                led_ok    = 1'b0;
                                                idle_bad  = 1'b0;
                                        end else begin
                                                if (scl_rise) begin
                                                        pend_bit   = i2c_sda;   // counts only once scl falls again
                                                        pend_valid = 1'b1;
                                                end
                                                if (scl_fall && pend_valid) begin
                                                        bits       = {bits[frame_bits-2:0], pend_bit};
                                                        pulses++;
                                                        pend_valid = 1'b0;
                                                end
                                        end
                                        if (led !== 8'h00 && !led_bad) begin
                                                led_bad = 1'b1;
                                                report_mismatch("led during frame", 8'h00, led);
                                        end
                                end
                                i2c_write_pkg::STOP: begin
                                        wait_cnt++;
                                        if (start_c || stop_c)
                                                report_problem("extra start or stop after the frame");
                                        else if (bus_busy && !idle_bad) begin
                                                idle_bad = 1'b1;
                                                report_problem("bus not idle after the stop condition");
                                        end
                                        if (led === exp_req.wr_data)
                                                led_ok = 1'b1;
                                        if (wait_cnt == led_limit && !led_ok)
                                                report_mismatch("led after stop", exp_req.wr_data, led);
                                        if (wait_cnt == idle_after) begin
                                                close_test();
                                                mon_state = i2c_write_pkg::DONE;
                                        end
                                end
                                default: ;      // frame closed, quiet until the next reset
                        endcase
                        scl_q = i2c_scl;
                        sda_q = i2c_sda;
                end
        end

endmodule

//--- tb_i2c_write.sv
// testbench top for the one-shot i2c eeprom byte writer
// applies a table of write requests, one reset per entry, and leaves all
// bus and status checking to i2c_bus_monitor

`timescale 1ns/1ps

module tb_i2c_write;

        localparam int powerup_cycles = 20;
        localparam int qtr_div        = 4;
        localparam int frame_qticks   = 116;
        localparam int n_tests        = 6;
        localparam int frame_wait     = powerup_cycles + frame_qticks * qtr_div + 40;
        localparam int cycle_limit    = n_tests * (powerup_cycles + frame_qticks * qtr_div + 50);

        logic       sys_clk;
        logic       sys_rst_n;
        logic [2:0] blk_sel;
        logic [7:0] mem_addr;
        logic [7:0] wr_data;
        wire        i2c_scl;
        wire  [7:0] led;
        wire        i2c_sda;

        string                   tbl_name [n_tests];
        logic [2:0]              tbl_blk  [n_tests];
        logic [7:0]              tbl_addr [n_tests];
        logic [7:0]              tbl_data [n_tests];
        i2c_write_pkg::i2c_req_t exp_req;
        logic [7:0]              lfsr = 8'd90;
        int                      cycle_cnt = 0;
        int                      waited;
        int                      t;

        pullup (i2c_sda);       // bus resistor, no slave on the bus

        i2c_write_top #(
                .powerup_cycles (powerup_cycles),
                .qtr_div        (qtr_div)
        ) u_dut (
                .sys_clk   (sys_clk),
                .sys_rst_n (sys_rst_n),
                .blk_sel   (blk_sel),
                .mem_addr  (mem_addr),
                .wr_data   (wr_data),
                .i2c_scl   (i2c_scl),
                .led       (led),
                .i2c_sda   (i2c_sda)
        );

        i2c_bus_monitor #(
                .powerup_cycles (powerup_cycles),
                .qtr_div        (qtr_div)
        ) u_mon (
                .sys_clk   (sys_clk),
                .sys_rst_n (sys_rst_n),
                .i2c_scl   (i2c_scl),
                .i2c_sda   (i2c_sda),
                .led       (led)
        );

        initial sys_clk = 1'b0;
        always #5 sys_clk = ~sys_clk;

        always @(posedge sys_clk) begin
                cycle_cnt++;
                if (cycle_cnt >= cycle_limit) begin
                        $display("run stopped after %0d cycles without finishing", cycle_cnt);
                        $display("TESTBENCH FAILED");
                        $finish;
                end
        end

        // 8-bit fibonacci lfsr, taps 8 6 5 4
        function automatic logic [7:0] lfsr_next(input logic [7:0] s);
                return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
        endfunction

        task automatic draw_bits(input int n, output logic [7:0] val);
                val = '0;
                for (int i = 0; i < n; i++) begin
                        val  = {val[6:0], lfsr[7]};
                        lfsr = lfsr_next(lfsr);
                end
        endtask

        task automatic fill_table();
                logic [7:0] v;
                tbl_name[0] = "source_values";
                tbl_blk[0]  = 3'd0;
                tbl_addr[0] = 8'h02;
                tbl_data[0] = 8'h55;
                tbl_name[1] = "all_zeros";
                tbl_blk[1]  = 3'd0;
                tbl_addr[1] = 8'h00;
                tbl_data[1] = 8'h00;
                tbl_name[2] = "all_ones";
                tbl_blk[2]  = 3'd7;
                tbl_addr[2] = 8'hff;
                tbl_data[2] = 8'hff;
                for (int i = 3; i < n_tests; i++) begin
                        tbl_name[i] = $sformatf("random_%0d", i - 3);
                        draw_bits(3, v);
                        tbl_blk[i] = v[2:0];
                        draw_bits(8, tbl_addr[i]);
                        draw_bits(8, tbl_data[i]);
                end
        endtask

        initial begin
                sys_rst_n = 1'b0;
                blk_sel   = 3'd0;
                mem_addr  = 8'h00;
                wr_data   = 8'h00;
                fill_table();
                for (t = 0; t < n_tests; t++) begin
                        @(posedge sys_clk);
                        sys_rst_n <= 1'b0;
                        blk_sel   <= tbl_blk[t];
                        mem_addr  <= tbl_addr[t];
                        wr_data   <= tbl_data[t];
                        exp_req.blk_sel  = tbl_blk[t];
                        exp_req.mem_addr = tbl_addr[t];
                        exp_req.wr_data  = tbl_data[t];
                        @(negedge sys_clk);
                        u_mon.arm_frame(tbl_name[t], exp_req);
                        repeat (5) @(posedge sys_clk);
                        sys_rst_n <= 1'b1;
                        waited = 0;
                        while (!u_mon.frame_closed && waited < frame_wait) begin
                                @(posedge sys_clk);
                                waited++;
                        end
                        if (!u_mon.frame_closed)
                                u_mon.report_missing(frame_wait);
                end
                $display("summary: %0d tests, %0d passed, %0d failed",
                         n_tests, u_mon.pass_count, u_mon.fail_count);
                if (u_mon.fail_count == 0 && u_mon.pass_count == n_tests)
                        $display("TESTBENCH PASSED");
                else
                        $display("TESTBENCH FAILED");
                $finish;
        end

endmodule

//--- list.f
i2c_write_pkg.sv
i2c_launch_ctrl.sv
i2c_write_fsm.sv
i2c_output_stage.sv
i2c_write_top.sv
i2c_bus_monitor.sv
tb_i2c_write.sv
